// ==== Makefile ====
# Verilator build and run of the RDMX data checker testbench

VERILATOR ?= verilator
TOP       ?= tb_rdmx_data_checker
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test passed

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/rdmx_checker_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module rdmx_checker_props (
    input wire                                   clk,
    input wire                                   resetn,
    input checker_pkg::chk_state_e               state,
    input wire [checker_pkg::CHK_ERR_BITS-1:0]   error,
    input wire                                   beat_valid,
    input wire [31:0]                            total_packets
);

    import checker_pkg::*;

    // No beat reaches the checker while it waits for a pattern
    a_no_beat_while_idle: assert property (@(posedge clk) disable iff (!resetn)
        (state == GET_PATTERN && error == '0) |-> !beat_valid)
        else $error("beat arrived while waiting for a pattern");

    // Error bits are sticky until reset
    a_error_sticky: assert property (@(posedge clk) disable iff (!resetn)
        $past(resetn) |-> (($past(error) & ~error) == '0))
        else $error("error bit cleared without reset");

    a_total_monotonic: assert property (@(posedge clk) disable iff (!resetn)
        $past(resetn) |-> (total_packets >= $past(total_packets)))
        else $error("total_packets decreased");

endmodule

bind rdmx_stream_checker rdmx_checker_props u_props (
    .clk           (clk),
    .resetn        (resetn),
    .state         (state),
    .error         (error),
    .beat_valid    (beat.valid),
    .total_packets (total_packets)
);

`default_nettype wire

// ==== bench/tb_rdmx_data_checker.sv ====
`timescale 1ns/1ns
`include "rdmx_config.svh"
`default_nettype none

module tb_rdmx_data_checker;

    import rdmx_pkt_pkg::*;
    import checker_pkg::*;

    // Scenario count and a generous cycle budget per scenario size the watchdog
    localparam int N_SCEN      = 14;
    localparam int SCEN_CYCLES = 600;
    localparam int WATCHDOG_NS = N_SCEN * SCEN_CYCLES * 4;

    logic                          clk;
    logic                          resetn;
    rdmx_cfg_t                     cfg;
    logic [31:0]                   pattern_tdata;
    logic                          pattern_tvalid;
    wire                           pattern_tready;
    logic [`RDMX_BEAT_BITS-1:0]    eth_tdata;
    logic                          eth_tvalid;
    logic                          eth_tlast;
    logic                          eth_tuser;
    wire                           eth_tready;
    wire [`RDMX_CNT_BITS-1:0]      total_packets;
    wire [`RDMX_CNT_BITS-1:0]      malformed_packets;
    wire [31:0]                    expected_fc;
    wire [31:0]                    expected_pattern;
    wire [CHK_ERR_BITS-1:0]        error;
    wire                           all_good;

    // Reference model state
    logic [31:0]             rng;
    logic [15:0]             m_seq;
    logic [63:0]             m_off;
    logic [31:0]             m_fc;
    logic [31:0]             m_pattern;
    logic [31:0]             m_total;
    logic [31:0]             m_malformed;
    logic [CHK_ERR_BITS-1:0] m_err;

    rdmx_data_checker u_dut (
        .clk               (clk),
        .resetn            (resetn),
        .cfg               (cfg),
        .pattern_tdata     (pattern_tdata),
        .pattern_tvalid    (pattern_tvalid),
        .pattern_tready    (pattern_tready),
        .eth_tdata         (eth_tdata),
        .eth_tvalid        (eth_tvalid),
        .eth_tlast         (eth_tlast),
        .eth_tuser         (eth_tuser),
        .eth_tready        (eth_tready),
        .total_packets     (total_packets),
        .malformed_packets (malformed_packets),
        .expected_fc       (expected_fc),
        .expected_pattern  (expected_pattern),
        .error             (error),
        .all_good          (all_good)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the DUT stopped accepting stream data");
        $display("Test failed");
        $fatal(1);
    end

    // Numerical Recipes LCG constants
    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // Wire order puts the first byte at the bottom of the beat
    function automatic logic [`RDMX_BEAT_BITS-1:0] swap_bytes(input logic [`RDMX_BEAT_BITS-1:0] v);
        logic [`RDMX_BEAT_BITS-1:0] r;
        for (int i = 0; i < `RDMX_BEAT_BYTES; i++) begin
            r[8*i +: 8] = v[8*(`RDMX_BEAT_BYTES-1-i) +: 8];
        end
        return r;
    endfunction

    // Header fields at their big-endian offsets, then put back in wire order
    function automatic logic [`RDMX_BEAT_BITS-1:0] header_beat(input logic [15:0] magic,
                                                               input logic [15:0] ip_len,
                                                               input logic [63:0] addr,
                                                               input logic [15:0] seq);
        logic [`RDMX_BEAT_BITS-1:0] be;
        be            = '0;
        be[175:160]   = magic;
        be[383:368]   = ip_len;
        be[159:96]    = addr;
        be[95:80]     = seq;
        return swap_bytes(be);
    endfunction

    function automatic logic [`RDMX_BEAT_BITS-1:0] garbage_beat();
        logic [`RDMX_BEAT_BITS-1:0] d;
        for (int i = 0; i < 16; i++) begin
            d[32*i +: 32] = next_rand();
        end
        return d;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Drives one beat after a random idle gap and waits for its transfer
    task automatic send_beat(input logic [`RDMX_BEAT_BITS-1:0] data, input logic last,
                             input logic user);
        int gap;
        gap = int'(next_rand() % 32'd3);
        repeat (gap) @(negedge clk);
        eth_tdata  = data;
        eth_tlast  = last;
        eth_tuser  = user;
        eth_tvalid = 1'b1;
        #1;
        while (!eth_tready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        eth_tvalid = 1'b0;
    endtask

    task automatic send_pattern(input logic [31:0] p);
        pattern_tdata  = p;
        pattern_tvalid = 1'b1;
        #1;
        while (!pattern_tready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        pattern_tvalid = 1'b0;
        m_fc      = m_fc + 32'd1;
        m_pattern = p;
    endtask

    function automatic void flag(input int bit_pos);
        if (m_err == '0) begin
            m_err[bit_pos] = 1'b1;
        end
    endfunction

    // Fault codes: 1 to 4 header field, 5 payload data, 6 payload length,
    // 7 frame counter value, 8 malformed packet
    task automatic send_fd_packet(input logic [31:0] p, input int fault);
        logic [15:0] magic;
        logic [15:0] ip_len;
        logic [63:0] addr;
        logic [15:0] seq;
        logic [`RDMX_BEAT_BITS-1:0] d;
        int n_pay;
        magic  = `RDMX_MAGIC;
        ip_len = cfg.packet_size + 16'd`RDMX_IP_OVERHEAD;
        addr   = cfg.rfd_addr + m_off;
        seq    = m_seq;
        n_pay  = (fault == 6) ? 1 : int'(cfg.packet_size) / `RDMX_BEAT_BYTES;
        case (fault)
            1: magic  = magic ^ 16'h0001;
            2: seq    = seq + 16'd1;
            3: ip_len = ip_len + 16'd1;
            4: addr   = addr ^ 64'h40;
            default: ;
        endcase
        if (fault >= 1 && fault <= 4) flag(int'(FD_MAGIC) + fault - 1);
        if (fault == 5) flag(int'(FD_DATA));
        if (fault == 6) flag(int'(FD_PLEN));
        send_beat((fault == 8) ? garbage_beat() : header_beat(magic, ip_len, addr, seq),
                  1'b0, fault == 8);
        for (int i = 0; i < n_pay; i++) begin
            d = {16{p}};
            if (fault == 5 && i == 0) d[37] = ~d[37];
            if (fault == 8) d = garbage_beat();
            send_beat(d, i == n_pay - 1, fault == 8);
        end
        // Model update follows the addressing and counting rules
        m_seq   = m_seq + 16'd1;
        m_total = m_total + 32'd1;
        if (fault == 8) m_malformed = m_malformed + 32'd1;
        if (m_off + 64'(cfg.packet_size) < cfg.rfd_size) begin
            m_off = m_off + 64'(cfg.packet_size);
        end else begin
            m_off = '0;
        end
    endtask

    task automatic send_fc_packet(input int fault);
        logic [15:0] magic;
        logic [15:0] ip_len;
        logic [63:0] addr;
        logic [15:0] seq;
        logic [`RDMX_BEAT_BITS-1:0] d;
        magic  = `RDMX_MAGIC;
        ip_len = 16'd`RDMX_FC_PAYLOAD + 16'd`RDMX_IP_OVERHEAD;
        addr   = cfg.rfc_addr;
        seq    = m_seq;
        case (fault)
            1: magic  = magic ^ 16'h8000;
            2: seq    = seq - 16'd1;
            3: ip_len = ip_len + 16'd4;
            4: addr   = addr + 64'h100;
            default: ;
        endcase
        if (fault >= 1 && fault <= 4) flag(int'(FC_MAGIC) + fault - 1);
        if (fault == 7) flag(int'(FC_VALUE));
        send_beat(header_beat(magic, ip_len, addr, seq), 1'b0, 1'b0);
        d = garbage_beat();
        d[31:0] = (fault == 7) ? m_fc + 32'd1 : m_fc;
        send_beat(d, 1'b1, 1'b0);
        m_seq   = m_seq + 16'd1;
        m_total = m_total + 32'd1;
    endtask

    // Packet index 4 is the frame-counter packet
    task automatic half_frame(input int f_pkt, input int fault);
        logic [31:0] p;
        p = next_rand();
        send_pattern(p);
        for (int i = 0; i < 4; i++) begin
            send_fd_packet(p, (i == f_pkt) ? fault : 0);
        end
        send_fc_packet((f_pkt == 4) ? fault : 0);
    endtask

    task automatic reset_dut();
        resetn         = 1'b0;
        pattern_tvalid = 1'b0;
        pattern_tdata  = '0;
        eth_tvalid     = 1'b0;
        eth_tdata      = '0;
        eth_tlast      = 1'b0;
        eth_tuser      = 1'b0;
        repeat (16) @(negedge clk);
        resetn      = 1'b1;
        m_seq       = 16'd1;
        m_off       = '0;
        m_fc        = '0;
        m_pattern   = '0;
        m_total     = '0;
        m_malformed = '0;
        m_err       = '0;
    endtask

    // Two register stages separate a transfer from the status outputs
    task automatic check_status();
        repeat (3) @(negedge clk);
        check_value(64'(error), 64'(m_err), "error");
        check_value(64'(all_good), 64'(m_err == '0), "all_good");
        check_value(64'(malformed_packets), 64'(m_malformed), "malformed_packets");
        check_value(64'(expected_pattern), 64'(m_pattern), "expected_pattern");
        if (m_err == '0) begin
            check_value(64'(total_packets), 64'(m_total), "total_packets");
            check_value(64'(expected_fc), 64'(m_fc), "expected_fc");
        end else begin
            // Once an error is set both streams must drain
            check_value(64'(pattern_tready), 64'd1, "pattern_tready after error");
            check_value(64'(eth_tready), 64'd1, "eth_tready after error");
            send_pattern(next_rand());
            send_beat(garbage_beat(), 1'b1, 1'b0);
        end
    endtask

    initial begin
        int hf;
        int kind;
        rng = 32'h48ea_f227;
        cfg.packet_size = 16'd128;
        cfg.frame_size  = 32'd1024;
        cfg.rfd_addr    = 64'h1000_0000;
        cfg.rfd_size    = 64'h300;
        cfg.rfc_addr    = 64'h2000_0000;
        reset_dut();

        // Ethernet stays blocked until a pattern arrives
        eth_tvalid = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            #1;
            check_value(64'(eth_tready), 64'd0, "eth_tready before pattern");
            check_value(64'(pattern_tready), 64'd1, "pattern_tready while idle");
        end
        @(negedge clk);
        eth_tvalid = 1'b0;

        // Clean half-frames
        reset_dut();
        hf = 2 + int'(next_rand() % 32'd3);
        repeat (hf) half_frame(-1, 0);
        check_status();
        // Four data packets and one counter packet per half-frame
        check_value(64'(total_packets), 64'(5 * hf), "total_packets after clean run");
        check_value(64'(expected_fc), 64'(hf), "expected_fc after clean run");

        // Payload and frame counter faults
        for (int f = 5; f <= 7; f++) begin
            reset_dut();
            half_frame(-1, 0);
            half_frame((f == 7) ? 4 : int'(next_rand() % 32'd4), f);
            check_status();
        end

        // Address fault on a packet whose offset has wrapped
        reset_dut();
        half_frame(-1, 0);
        half_frame(2, 4);
        check_status();

        // Random header faults in either packet kind
        repeat (7) begin
            reset_dut();
            kind = int'(next_rand() % 32'd2);
            half_frame(-1, 0);
            half_frame((kind == 1) ? 4 : int'(next_rand() % 32'd4),
                       1 + int'(next_rand() % 32'd4));
            check_status();
        end

        // Packet flagged by tuser is counted and not checked
        reset_dut();
        half_frame(-1, 0);
        half_frame(int'(next_rand() % 32'd4), 8);
        check_status();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== checker/rdmx_addr_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module rdmx_addr_tracker (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       advance,
    input  wire rdmx_pkt_pkg::rdmx_cfg_t cfg,
    output logic [63:0]               expected_fd_addr
);

    // Offset of the next frame-data packet inside the frame-data window
    logic [63:0] fd_offset;

    // Offset after this packet if the window does not wrap
    wire [63:0] next_offset = fd_offset + 64'(cfg.packet_size);

    // Step one packet per frame-data header
    // A packet that would start at or past the window end wraps to offset 0
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fd_offset <= '0;
        end else if (advance) begin
            if (next_offset < cfg.rfd_size) begin
                fd_offset <= next_offset;
            end else begin
                fd_offset <= '0;
            end
        end
    end

    // Target address the next frame-data header must carry
    assign expected_fd_addr = cfg.rfd_addr + fd_offset;

endmodule

`default_nettype wire

// ==== checker/rdmx_stream_checker.sv ====
`timescale 1ns/1ns
`include "rdmx_config.svh"
`default_nettype none

module rdmx_stream_checker (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire rdmx_pkt_pkg::rdmx_beat_t beat,
    input  wire rdmx_pkt_pkg::rdmx_cfg_t  cfg,
    input  wire [63:0]                   expected_fd_addr,
    input  wire [31:0]                   pattern_tdata,
    input  wire                          pattern_tvalid,
    input  wire                          eth_tvalid,
    output logic                         pattern_tready,
    output logic                         eth_tready,
    output logic                         advance,
    output logic [`RDMX_CNT_BITS-1:0]    total_packets,
    output logic [`RDMX_CNT_BITS-1:0]    malformed_packets,
    output logic [31:0]                  expected_fc,
    output logic [31:0]                  expected_pattern,
    output logic [checker_pkg::CHK_ERR_BITS-1:0] error,
    output logic                         all_good
);

    import rdmx_pkt_pkg::*;
    import checker_pkg::*;

    // IPv4 length of the frame-counter packet is fixed
    localparam logic [15:0] FC_IP_LENGTH = 16'(`RDMX_FC_PAYLOAD + `RDMX_IP_OVERHEAD);

    chk_state_e                state;
    logic [15:0]               expected_seq;
    // Payload beats seen so far in the current packet
    logic [15:0]               beat_cnt;
    // Frame-data packets started in this half-frame
    logic [31:0]               fd_pkt_cnt;
    // Error bits raised by the beat in the register this cycle
    logic [CHK_ERR_BITS-1:0]   fault;

    wire [15:0] fd_ip_length  = cfg.packet_size + 16'(`RDMX_IP_OVERHEAD);
    wire [15:0] fd_beats      = cfg.packet_size / 16'(`RDMX_BEAT_BYTES);
    wire [31:0] hframe_pkts   = packets_per_hframe(cfg.packet_size, cfg.frame_size);
    wire [15:0] next_beat_cnt = beat_cnt + 16'd1;

    // Every frame-data payload beat is the pattern repeated across the beat
    wire [`RDMX_BEAT_BITS-1:0] expected_data = {(`RDMX_BEAT_BITS/32){expected_pattern}};

    wire pattern_xfer = pattern_tvalid & pattern_tready;

    // The last frame-counter beat is still in the register while the FSM is
    // in FC_PAYLOAD, so hold off the next offered beat for that one cycle
    // It would otherwise land while the FSM waits for a pattern
    wire fc_drain_hold = (state == FC_PAYLOAD) & beat.valid & eth_tvalid;

    // ==================================================
    // Stream handshakes
    // ==================================================

    // A set error opens both streams so the upstream keeps flowing
    assign pattern_tready = resetn & ((error != '0) | (state == GET_PATTERN));
    assign eth_tready     = resetn & ((error != '0) | ((state != GET_PATTERN) & !fc_drain_hold));

    assign all_good = (error == '0);

    // Mismatch bits for one header, ordered magic, sequence, length, address
    function automatic logic [3:0] hdr_faults(input rdmx_hdr_t   hdr,
                                              input logic [15:0] seq,
                                              input logic [15:0] ip_length,
                                              input logic [63:0] addr);
        hdr_faults[0] = (hdr.magic != `RDMX_MAGIC);
        hdr_faults[1] = (hdr.seq_num != seq);
        hdr_faults[2] = (hdr.ip4_length != ip_length);
        hdr_faults[3] = (hdr.rdmx_address != addr);
    endfunction

    // ==================================================
    // Per-beat comparisons
    // ==================================================

    // Beats flagged by tuser carry no trustworthy content and are not checked
    always_comb begin
        fault = '0;
        if (beat.valid && beat.well_formed) begin
            case (state)
                FD_HEADER: begin
                    fault[FD_MAGIC +: 4] = hdr_faults(beat.hdr, expected_seq, fd_ip_length,
                                                      expected_fd_addr);
                end
                FD_PAYLOAD: begin
                    fault[FD_DATA] = (beat.data != expected_data);
                    fault[FD_PLEN] = beat.last && (next_beat_cnt != fd_beats);
                end
                FC_HEADER: begin
                    fault[FC_MAGIC +: 4] = hdr_faults(beat.hdr, expected_seq, FC_IP_LENGTH,
                                                      cfg.rfc_addr);
                end
                FC_PAYLOAD: begin
                    fault[FC_VALUE] = (beat.frame_counter != expected_fc);
                    fault[FC_PLEN]  = beat.last && (next_beat_cnt != 16'd1);
                end
                default: ;
            endcase
        end
    end

    // ==================================================
    // Packet sequence FSM and bookkeeping
    // ==================================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state             <= GET_PATTERN;
            error             <= '0;
            total_packets     <= '0;
            malformed_packets <= '0;
            expected_fc       <= '0;
            expected_pattern  <= '0;
            expected_seq      <= 16'd1;
            beat_cnt          <= '0;
            fd_pkt_cnt        <= '0;
            advance           <= 1'b0;
        end else begin
            // Strobe for the address tracker, one cycle wide
            advance <= 1'b0;

            // Bad-FCS packets are counted even once checking has stopped
            if (beat.valid && beat.last && !beat.well_formed) begin
                malformed_packets <= malformed_packets + 1'b1;
            end

            // The first error freezes the FSM and the error vector
            if (error == '0) begin
                error <= fault;

                if (beat.valid && beat.last) begin
                    total_packets <= total_packets + 1'b1;
                    expected_seq  <= expected_seq + 16'd1;
                end

                case (state)
                    GET_PATTERN: begin
                        if (pattern_xfer) begin
                            expected_pattern <= pattern_tdata;
                            expected_fc      <= expected_fc + 32'd1;
                            fd_pkt_cnt       <= '0;
                            state            <= FD_HEADER;
                        end
                    end
                    FD_HEADER: begin
                        if (beat.valid) begin
                            advance    <= 1'b1;
                            fd_pkt_cnt <= fd_pkt_cnt + 32'd1;
                            beat_cnt   <= '0;
                            state      <= FD_PAYLOAD;
                        end
                    end
                    FD_PAYLOAD: begin
                        if (beat.valid) begin
                            beat_cnt <= next_beat_cnt;
                            // Half-frame complete, the frame counter comes next
                            if (beat.last) begin
                                state <= (fd_pkt_cnt == hframe_pkts) ? FC_HEADER : FD_HEADER;
                            end
                        end
                    end
                    FC_HEADER: begin
                        if (beat.valid) begin
                            beat_cnt <= '0;
                            state    <= FC_PAYLOAD;
                        end
                    end
                    FC_PAYLOAD: begin
                        if (beat.valid) begin
                            beat_cnt <= next_beat_cnt;
                            if (beat.last) begin
                                state <= GET_PATTERN;
                            end
                        end
                    end
                    default: state <= GET_PATTERN;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/checker_pkg.sv ====
`default_nettype none

package checker_pkg;

    // Where the checker is within a half-frame
    typedef enum logic [2:0] {
        GET_PATTERN,
        FD_HEADER,
        FD_PAYLOAD,
        FC_HEADER,
        FC_PAYLOAD
    } chk_state_e;

    // Bit positions in the sticky error vector
    // The four header bits of each packet kind sit next to each other in the
    // order magic, sequence, IPv4 length, target address
    typedef enum logic [3:0] {
        FD_MAGIC = 4'd0,
        FD_SEQ   = 4'd1,
        FD_PSIZE = 4'd2,
        FD_TADDR = 4'd3,
        FD_DATA  = 4'd4,
        FD_PLEN  = 4'd5,
        FC_MAGIC = 4'd6,
        FC_SEQ   = 4'd7,
        FC_PSIZE = 4'd8,
        FC_TADDR = 4'd9,
        FC_VALUE = 4'd10,
        FC_PLEN  = 4'd11
    } chk_err_e;

    localparam int CHK_ERR_BITS = 12;

    // Frame-data packets one checker sees per half-frame
    // The other half of the frame goes to the second Ethernet channel
    function automatic logic [31:0] packets_per_hframe(input logic [15:0] packet_size,
                                                       input logic [31:0] frame_size);
        logic [31:0] per_frame;
        case (packet_size)
            16'd64:   per_frame = frame_size / 32'd64;
            16'd128:  per_frame = frame_size / 32'd128;
            16'd256:  per_frame = frame_size / 32'd256;
            16'd512:  per_frame = frame_size / 32'd512;
            16'd1024: per_frame = frame_size / 32'd1024;
            16'd2048: per_frame = frame_size / 32'd2048;
            16'd4096: per_frame = frame_size / 32'd4096;
            16'd8192: per_frame = frame_size / 32'd8192;
            // Unsupported sizes fall back to one packet
            default:  return 32'd1;
        endcase
        return per_frame >> 1;
    endfunction

endpackage

`default_nettype wire

// ==== common/rdmx_config.svh ====
`ifndef RDMX_CONFIG_SVH
`define RDMX_CONFIG_SVH

// ==================================================
// Beat geometry of the Ethernet stream
// ==================================================

// One beat of the Ethernet stream carries 64 bytes
`define RDMX_BEAT_BITS 512
`define RDMX_BEAT_BYTES 64

// ==================================================
// RDMX packet constants
// ==================================================

// Every RDMX header starts its RDMX section with this magic number
`define RDMX_MAGIC 16'h0122

// IPv4 length is the RDMX payload size plus the IPv4, UDP and RDMX headers
`define RDMX_IP_OVERHEAD 50

// The frame-counter packet carries a single 32-bit counter
`define RDMX_FC_PAYLOAD 4

// Width of the completed and malformed packet counters
`define RDMX_CNT_BITS 32

`endif

// ==== common/rdmx_pkt_pkg.sv ====
`default_nettype none

`include "rdmx_config.svh"

package rdmx_pkt_pkg;

    // Header fields of interest, already converted to big-endian order
    typedef struct packed {
        logic [15:0] magic;
        logic [15:0] ip4_length;
        logic [63:0] rdmx_address;
        logic [15:0] seq_num;
    } rdmx_hdr_t;

    // One registered Ethernet beat as the checker sees it
    // The header fields are only meaningful on the first beat of a packet,
    // and frame_counter only on the payload beat of a frame-counter packet
    typedef struct packed {
        // High for exactly one cycle per accepted beat
        logic                        valid;
        // Copy of tlast for this beat
        logic                        last;
        // Low when the MAC flagged this beat through tuser (bad FCS)
        logic                        well_formed;
        // Raw beat in the byte order it arrived in
        logic [`RDMX_BEAT_BITS-1:0]  data;
        rdmx_hdr_t                   hdr;
        // Raw bits 31:0 of the beat, no byte swap
        logic [31:0]                 frame_counter;
    } rdmx_beat_t;

    // Run-time configuration of the checker
    typedef struct packed {
        // Frame-data packet payload size in bytes, a power of two
        logic [15:0] packet_size;
        // Size of a full frame in bytes, both halves together
        logic [31:0] frame_size;
        // Window of target addresses that frame-data packets cycle through
        logic [63:0] rfd_addr;
        logic [63:0] rfd_size;
        // Fixed target address of the frame-counter packet
        logic [63:0] rfc_addr;
    } rdmx_cfg_t;

endpackage

`default_nettype wire

// ==== hw/rdmx_data_checker.sv ====
`timescale 1ns/1ns
`include "rdmx_config.svh"
`default_nettype none

module rdmx_data_checker (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire rdmx_pkt_pkg::rdmx_cfg_t  cfg,

    // Pattern stream, one 32-bit pattern per half-frame
    input  wire [31:0]                    pattern_tdata,
    input  wire                           pattern_tvalid,
    output wire                           pattern_tready,

    // Ethernet stream from the MAC
    input  wire [`RDMX_BEAT_BITS-1:0]     eth_tdata,
    input  wire                           eth_tvalid,
    input  wire                           eth_tlast,
    input  wire                           eth_tuser,
    output wire                           eth_tready,

    // Status
    output wire [`RDMX_CNT_BITS-1:0]      total_packets,
    output wire [`RDMX_CNT_BITS-1:0]      malformed_packets,
    output wire [31:0]                    expected_fc,
    output wire [31:0]                    expected_pattern,
    output wire [checker_pkg::CHK_ERR_BITS-1:0] error,
    output wire                           all_good
);

    import rdmx_pkt_pkg::*;

    // Registered beat from the extractor, one cycle behind the transfer
    wire rdmx_beat_t beat;
    // Tracker step request and its result
    wire             advance;
    wire [63:0]      expected_fd_addr;

    rdmx_header_extract u_extract (
        .clk        (clk),
        .resetn     (resetn),
        .eth_tdata  (eth_tdata),
        .eth_tvalid (eth_tvalid),
        .eth_tlast  (eth_tlast),
        .eth_tuser  (eth_tuser),
        .eth_tready (eth_tready),
        .beat       (beat)
    );

    rdmx_addr_tracker u_addr (
        .clk              (clk),
        .resetn           (resetn),
        .advance          (advance),
        .cfg              (cfg),
        .expected_fd_addr (expected_fd_addr)
    );

    rdmx_stream_checker u_check (
        .clk               (clk),
        .resetn            (resetn),
        .beat              (beat),
        .cfg               (cfg),
        .expected_fd_addr  (expected_fd_addr),
        .pattern_tdata     (pattern_tdata),
        .pattern_tvalid    (pattern_tvalid),
        .eth_tvalid        (eth_tvalid),
        .pattern_tready    (pattern_tready),
        .eth_tready        (eth_tready),
        .advance           (advance),
        .total_packets     (total_packets),
        .malformed_packets (malformed_packets),
        .expected_fc       (expected_fc),
        .expected_pattern  (expected_pattern),
        .error             (error),
        .all_good          (all_good)
    );

endmodule

`default_nettype wire

// ==== hw/rdmx_header_extract.sv ====
`timescale 1ns/1ns
`include "rdmx_config.svh"
`default_nettype none

module rdmx_header_extract (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire [`RDMX_BEAT_BITS-1:0]  eth_tdata,
    input  wire                        eth_tvalid,
    input  wire                        eth_tlast,
    input  wire                        eth_tuser,
    input  wire                        eth_tready,
    output rdmx_pkt_pkg::rdmx_beat_t   beat
);

    // Big-endian view of the incoming beat
    logic [`RDMX_BEAT_BITS-1:0] be_data;

    // The extractor never stalls, so every stream transfer is captured
    wire eth_xfer = eth_tvalid & eth_tready;

    // First byte on the wire lands in the top byte of be_data
    always_comb begin
        for (int i = 0; i < `RDMX_BEAT_BYTES; i++) begin
            be_data[8*i +: 8] = eth_tdata[8*(`RDMX_BEAT_BYTES-1-i) +: 8];
        end
    end

    // ==================================================
    // Header layout after the swap
    // ==================================================
    // 511:400 Ethernet MACs and frame type
    // 399:240 IPv4 header, length in 383:368
    // 239:176 UDP header
    // 175:160 RDMX magic, 159:96 target address, 95:80 sequence number

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat.valid <= 1'b0;
        end else begin
            beat.valid <= eth_xfer;
        end

        // Payload follows the transfer and holds its value between beats
        if (eth_xfer) begin
            beat.last              <= eth_tlast;
            beat.well_formed       <= !eth_tuser;
            beat.data              <= eth_tdata;
            beat.hdr.magic         <= be_data[175:160];
            beat.hdr.ip4_length    <= be_data[383:368];
            beat.hdr.rdmx_address  <= be_data[159:96];
            beat.hdr.seq_num       <= be_data[95:80];
            // The frame counter is read in wire order, little-endian
            beat.frame_counter     <= eth_tdata[31:0];
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/rdmx_pkt_pkg.sv
common/checker_pkg.sv
hw/rdmx_header_extract.sv
checker/rdmx_addr_tracker.sv
checker/rdmx_stream_checker.sv
hw/rdmx_data_checker.sv
bench/rdmx_checker_props.sv
bench/tb_rdmx_data_checker.sv
